// File: nx_pkg.sv
// Link widths, configuration register map and shared struct types
package nx_pkg;

// Bus and word geometry
localparam int NX_BUS_WIDTH  = 8;
localparam int NX_DATA_WIDTH = 32;
// Chunks per word
localparam int NX_MAX_TICKS  = 4;
// Transmit FIFO entries
localparam int NX_FIFO_DEPTH = 2;
// Event counter width
localparam int NX_CNT_WIDTH  = 16;

// Configuration register map
localparam int NX_CFG_ADDR_WIDTH = 2;
localparam logic [NX_CFG_ADDR_WIDTH-1:0] NX_CFG_CTRL   = 2'd0;
localparam logic [NX_CFG_ADDR_WIDTH-1:0] NX_CFG_WORDS  = 2'd1;
localparam logic [NX_CFG_ADDR_WIDTH-1:0] NX_CFG_CHUNKS = 2'd2;
localparam logic [NX_CFG_ADDR_WIDTH-1:0] NX_CFG_DROPS  = 2'd3;

// Input word and FIFO entry, one strobe bit per bus chunk
typedef struct packed {
    logic [NX_DATA_WIDTH-1:0] data;
    logic [NX_MAX_TICKS-1:0]  strb;
} nx_tx_word_t;

// One transfer on the narrow bus
typedef struct packed {
    logic [NX_BUS_WIDTH-1:0] data;
    logic                    last;
} nx_bus_beat_t;

// Compacted word, count runs 1 to NX_MAX_TICKS
typedef struct packed {
    logic [NX_DATA_WIDTH-1:0]           data;
    logic [$clog2(NX_MAX_TICKS+1)-1:0] count;
} nx_rx_word_t;

// Control register, tx_enable in bit 0
typedef struct packed {
    logic send_all;
    logic tx_enable;
} nx_cfg_t;

// Single-cycle event pulses, word_sent in bit 0
typedef struct packed {
    logic word_dropped;
    logic chunk_sent;
    logic word_sent;
} nx_tx_events_t;

endpackage

// File: nx_fifo.sv
// Synchronous circular-buffer FIFO with occupancy level and empty/full flags
`timescale 1ns/1ns

module nx_fifo #(
      parameter int DEPTH = 2
    , parameter int WIDTH = 32
) (
      input  logic                       clk_i
    , input  logic                       reset_i
    // Write side
    , input  logic [WIDTH-1:0]           wr_data_i
    , input  logic                       wr_push_i
    // Read side with the head entry always visible
    , output logic [WIDTH-1:0]           rd_data_o
    , input  logic                       rd_pop_i
    // Status
    , output logic [$clog2(DEPTH+1)-1:0] level_o
    , output logic                       empty_o
    , output logic                       full_o
);

// Storage array
logic [WIDTH-1:0]           mem_q [DEPTH];
logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
logic [$clog2(DEPTH+1)-1:0] level_q;
logic                       do_push;
logic                       do_pop;

// Pointer increment with wrap at DEPTH
function automatic logic [$clog2(DEPTH)-1:0] next_ptr(input logic [$clog2(DEPTH)-1:0] ptr);
    if (ptr == DEPTH - 1) return '0;
    return ptr + 1'b1;
endfunction

assign empty_o   = (level_q == '0);
assign full_o    = (level_q == DEPTH);
assign level_o   = level_q;
assign rd_data_o = mem_q[rd_ptr_q];

// Ignore push when full and pop when empty
assign do_push = wr_push_i && !full_o;
assign do_pop  = rd_pop_i && !empty_o;

always_ff @(posedge clk_i) begin : s_store
    if (do_push) begin
        mem_q[wr_ptr_q] <= wr_data_i;
    end
end

always_ff @(posedge clk_i) begin : s_pointers
    if (reset_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        level_q  <= '0;
    end else begin
        if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
        if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
        // Push and pop together leave the level unchanged
        case ({do_push, do_pop})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
        endcase
    end
end

endmodule

// File: nx_transmitter.sv
// Transmitter: FIFO plus chunk-mask serializer driving the narrow bus
`timescale 1ns/1ns

module nx_transmitter
    import nx_pkg::*;
(
      input  logic          clk_i
    , input  logic          reset_i
    // Word interface
    , input  nx_tx_word_t   tx_word_i
    , input  logic          tx_valid_i
    , output logic          tx_ready_o
    // Steering from the config block
    , input  nx_cfg_t       cfg_i
    // Bus interface
    , output nx_bus_beat_t  bus_beat_o
    , output logic          bus_valid_o
    , input  logic          bus_ready_i
    // Event pulses back to the counters
    , output nx_tx_events_t events_o
);

nx_tx_word_t                     head_word;
logic                            fifo_empty;
logic                            fifo_full;
logic                            fifo_pop;
// Chunks of the head word still to send
logic [NX_MAX_TICKS-1:0]         mask_q;
logic [NX_MAX_TICKS-1:0]         start_mask;
logic [NX_MAX_TICKS-1:0]         mask_rest;
logic [$clog2(NX_MAX_TICKS)-1:0] chunk_idx;
logic                            head_start;
logic                            drop_word;
logic                            beat_done;

assign tx_ready_o = ~fifo_full;

// Send-all overrides the strobe
assign start_mask = cfg_i.send_all ? '1 : head_word.strb;

// Idle with a head word and enabled, so the mask gets loaded
assign head_start = ~|mask_q && !fifo_empty && cfg_i.tx_enable;
// Nothing to send, popped straight away
assign drop_word  = head_start && ~|start_mask;

// Lowest pending chunk goes out first
always_comb begin : c_chunk_sel
    chunk_idx = '0;
    for (int i = NX_MAX_TICKS - 1; i >= 0; i--) begin
        if (mask_q[i]) chunk_idx = ($clog2(NX_MAX_TICKS))'(i);
    end
end

// Mask with its lowest set bit cleared
assign mask_rest = mask_q & (mask_q - 1'b1);

// Beat held stable by the FIFO head until accepted
assign bus_valid_o     = |mask_q;
assign bus_beat_o.data = head_word.data[chunk_idx*NX_BUS_WIDTH +: NX_BUS_WIDTH];
assign bus_beat_o.last = ~|mask_rest;
assign beat_done       = bus_valid_o && bus_ready_i;

// Head leaves on its final beat or on drop
assign fifo_pop = (beat_done && bus_beat_o.last) || drop_word;

assign events_o.chunk_sent   = beat_done;
assign events_o.word_sent    = beat_done && bus_beat_o.last;
assign events_o.word_dropped = drop_word;

always_ff @(posedge clk_i) begin : s_mask
    if (reset_i) begin
        mask_q <= '0;
    end else if (head_start) begin
        mask_q <= start_mask;
    end else if (beat_done) begin
        mask_q <= mask_rest;
    end
end

// Transmit FIFO
nx_fifo #(
      .DEPTH(NX_FIFO_DEPTH        )
    , .WIDTH($bits(nx_tx_word_t))
) m_fifo (
      .clk_i    (clk_i                   )
    , .reset_i  (reset_i                 )
    , .wr_data_i(tx_word_i               )
    , .wr_push_i(tx_valid_i && tx_ready_o)
    , .rd_data_o(head_word               )
    , .rd_pop_i (fifo_pop                )
    , .level_o  (                        )
    , .empty_o  (fifo_empty              )
    , .full_o   (fifo_full               )
);

endmodule

// File: nx_receiver.sv
// Receiver packing bus chunks upward from chunk 0 into a zero-filled word
`timescale 1ns/1ns

module nx_receiver
    import nx_pkg::*;
(
      input  logic         clk_i
    , input  logic         reset_i
    // Bus interface
    , input  nx_bus_beat_t bus_beat_i
    , input  logic         bus_valid_i
    , output logic         bus_ready_o
    // Word interface
    , output nx_rx_word_t  rx_word_o
    , output logic         rx_valid_o
    , input  logic         rx_ready_i
);

// Assembly register whose count doubles as the next slot
nx_rx_word_t asm_q;
// Complete word waiting for the consumer
logic        held_q;
logic        beat_take;
logic        word_take;
logic        word_end;
logic [$clog2(NX_MAX_TICKS)-1:0] slot;

// Stall the bus while a word is held
assign bus_ready_o = ~held_q;
assign beat_take   = bus_valid_i && bus_ready_o;
assign word_take   = held_q && rx_ready_i;

assign slot = asm_q.count[$clog2(NX_MAX_TICKS)-1:0];

// Last flag closes the word
assign word_end = bus_beat_i.last;

assign rx_word_o  = asm_q;
assign rx_valid_o = held_q;

// Cleared on consume so unused chunks read as zero
always_ff @(posedge clk_i) begin : s_assemble
    if (reset_i || word_take) begin
        asm_q <= '0;
    end else if (beat_take) begin
        asm_q.data[slot*NX_BUS_WIDTH +: NX_BUS_WIDTH] <= bus_beat_i.data;
        asm_q.count <= asm_q.count + 1'b1;
    end
end

// Hold flag
always_ff @(posedge clk_i) begin : s_hold
    if (reset_i) begin
        held_q <= 1'b0;
    end else if (word_take) begin
        held_q <= 1'b0;
    end else if (beat_take && word_end) begin
        // Valid on the cycle after last
        held_q <= 1'b1;
    end
end

endmodule

// File: nx_link_cfg.sv
// Control register and clearable event counters behind a simple register port
`timescale 1ns/1ns

module nx_link_cfg
    import nx_pkg::*;
(
      input  logic                         clk_i
    , input  logic                         reset_i
    // Register port
    , input  logic                         cfg_wr_i
    , input  logic [NX_CFG_ADDR_WIDTH-1:0] cfg_addr_i
    , input  logic [31:0]                  cfg_wdata_i
    , output logic [31:0]                  cfg_rdata_o
    // Transmitter side
    , output nx_cfg_t                      cfg_o
    , input  nx_tx_events_t                events_i
);

nx_cfg_t                   ctrl_q;
// Index 0 words, 1 chunks, 2 drops, same order as the event bits
logic [NX_CNT_WIDTH-1:0]   cnt_q [$bits(nx_tx_events_t)];
logic [$bits(nx_tx_events_t)-1:0] cnt_clr;
logic [$bits(nx_tx_events_t)-1:0] cnt_inc;

assign cfg_o   = ctrl_q;
assign cnt_inc = events_i;

// Any write to a counter address clears it
assign cnt_clr[0] = cfg_wr_i && (cfg_addr_i == NX_CFG_WORDS);
assign cnt_clr[1] = cfg_wr_i && (cfg_addr_i == NX_CFG_CHUNKS);
assign cnt_clr[2] = cfg_wr_i && (cfg_addr_i == NX_CFG_DROPS);

// Enabled, not send-all out of reset
always_ff @(posedge clk_i) begin : s_ctrl
    if (reset_i) begin
        ctrl_q.tx_enable <= 1'b1;
        ctrl_q.send_all  <= 1'b0;
    end else if (cfg_wr_i && (cfg_addr_i == NX_CFG_CTRL)) begin
        ctrl_q <= nx_cfg_t'(cfg_wdata_i[$bits(nx_cfg_t)-1:0]);
    end
end

// Clear wins over a same-cycle event
always_ff @(posedge clk_i) begin : s_counters
    for (int i = 0; i < $bits(nx_tx_events_t); i++) begin
        if (reset_i || cnt_clr[i]) cnt_q[i] <= '0;
        else if (cnt_inc[i]) cnt_q[i] <= cnt_q[i] + 1'b1;
    end
end

// Zero-extended read-back
always_comb begin : c_read
    cfg_rdata_o = '0;
    case (cfg_addr_i)
        NX_CFG_CTRL:   cfg_rdata_o[$bits(nx_cfg_t)-1:0] = ctrl_q;
        NX_CFG_WORDS:  cfg_rdata_o[NX_CNT_WIDTH-1:0] = cnt_q[0];
        NX_CFG_CHUNKS: cfg_rdata_o[NX_CNT_WIDTH-1:0] = cnt_q[1];
        NX_CFG_DROPS:  cfg_rdata_o[NX_CNT_WIDTH-1:0] = cnt_q[2];
        default:       cfg_rdata_o = '0;
    endcase
end

endmodule

// File: nx_link_top.sv
// Link top: config block, transmitter and receiver joined by the internal bus
`timescale 1ns/1ns

module nx_link_top
    import nx_pkg::*;
(
      input  logic                         clk_i
    , input  logic                         reset_i
    // Word input
    , input  nx_tx_word_t                  tx_word_i
    , input  logic                         tx_valid_i
    , output logic                         tx_ready_o
    // Word output
    , output nx_rx_word_t                  rx_word_o
    , output logic                         rx_valid_o
    , input  logic                         rx_ready_i
    // Register port
    , input  logic                         cfg_wr_i
    , input  logic [NX_CFG_ADDR_WIDTH-1:0] cfg_addr_i
    , input  logic [31:0]                  cfg_wdata_i
    , output logic [31:0]                  cfg_rdata_o
);

// Internal narrow bus
nx_bus_beat_t  bus_beat;
logic          bus_valid;
logic          bus_ready;
// Steering and events
nx_cfg_t       link_cfg;
nx_tx_events_t tx_events;

nx_link_cfg m_cfg (
      .clk_i      (clk_i      )
    , .reset_i    (reset_i    )
    , .cfg_wr_i   (cfg_wr_i   )
    , .cfg_addr_i (cfg_addr_i )
    , .cfg_wdata_i(cfg_wdata_i)
    , .cfg_rdata_o(cfg_rdata_o)
    , .cfg_o      (link_cfg   )
    , .events_i   (tx_events  )
);

nx_transmitter m_tx (
      .clk_i      (clk_i     )
    , .reset_i    (reset_i   )
    , .tx_word_i  (tx_word_i )
    , .tx_valid_i (tx_valid_i)
    , .tx_ready_o (tx_ready_o)
    , .cfg_i      (link_cfg  )
    , .bus_beat_o (bus_beat  )
    , .bus_valid_o(bus_valid )
    , .bus_ready_i(bus_ready )
    , .events_o   (tx_events )
);

nx_receiver m_rx (
      .clk_i      (clk_i     )
    , .reset_i    (reset_i   )
    , .bus_beat_i (bus_beat  )
    , .bus_valid_i(bus_valid )
    , .bus_ready_o(bus_ready )
    , .rx_word_o  (rx_word_o )
    , .rx_valid_o (rx_valid_o)
    , .rx_ready_i (rx_ready_i)
);

endmodule

// File: tb_nx_link.sv
// Testbench for the narrow link with stimulus table, reference model and directed tests
`timescale 1ns/1ns

module tb_nx_link
    import nx_pkg::*;
();

localparam int NUM_VECS   = 10;
localparam int BURST_LEN  = 6;
localparam int WAIT_LIMIT = 200;

// One table row, expected count written from the strobe rule
typedef struct packed {
    logic [NX_DATA_WIDTH-1:0] data;
    logic [NX_MAX_TICKS-1:0]  strb;
    logic                     send_all;
    logic                     stall;
    logic [2:0]               exp_count;
} test_vec_t;

logic                         clk_i;
logic                         reset_i;
nx_tx_word_t                  tx_word_i;
logic                         tx_valid_i;
logic                         tx_ready_o;
nx_rx_word_t                  rx_word_o;
logic                         rx_valid_o;
logic                         rx_ready_i;
logic                         cfg_wr_i;
logic [NX_CFG_ADDR_WIDTH-1:0] cfg_addr_i;
logic [31:0]                  cfg_wdata_i;
logic [31:0]                  cfg_rdata_o;

integer    seed = 32'h9fe8aa01;
int        error_count = 0;
int        pass_count = 0;
int        fail_count = 0;
// Model totals for the counter read-back
int        model_words = 0;
int        model_chunks = 0;
int        model_drops = 0;
test_vec_t vec_table [NUM_VECS];
string     vec_name [NUM_VECS];

nx_link_top i_dut (.*);

initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
end

// Selected chunks in ascending order, packed from chunk 0, rest zero
function automatic logic [NX_DATA_WIDTH-1:0] compact_data(input logic [NX_DATA_WIDTH-1:0] data,
                                                          input logic [NX_MAX_TICKS-1:0] mask);
    logic [NX_DATA_WIDTH-1:0] result;
    int                       slot;
    result = '0;
    slot = 0;
    for (int i = 0; i < NX_MAX_TICKS; i++) begin
        if (mask[i]) begin
            result[slot*NX_BUS_WIDTH +: NX_BUS_WIDTH] = data[i*NX_BUS_WIDTH +: NX_BUS_WIDTH];
            slot++;
        end
    end
    return result;
endfunction

function automatic int chunk_count(input logic [NX_MAX_TICKS-1:0] mask);
    int n;
    n = 0;
    for (int i = 0; i < NX_MAX_TICKS; i++) begin
        if (mask[i]) n++;
    end
    return n;
endfunction

task automatic check_value(input string name, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
    if (exp !== act) begin
        $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
        error_count++;
    end
endtask

task automatic finish_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
        pass_count++;
        $display("PASS %s", name);
    end else begin
        fail_count++;
        $display("FAIL %s", name);
    end
endtask

task automatic abort_on_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("Test failures found");
    $finish;
endtask

task automatic set_vec(input int idx, input string name, input test_vec_t vec);
    vec_name[idx] = name;
    vec_table[idx] = vec;
endtask

task automatic load_table();
    // Name, data, strobe, send_all, random stall, expected count
    set_vec(0, "full_strobe",   {32'h4433_2211, 4'b1111, 1'b0, 1'b0, 3'd4});
    set_vec(1, "strobe_0101",   {32'hA1B2_C3D4, 4'b0101, 1'b0, 1'b0, 3'd2});
    set_vec(2, "strobe_1000",   {32'h8877_6655, 4'b1000, 1'b0, 1'b0, 3'd1});
    set_vec(3, "strobe_0110",   {32'hDEAD_BEEF, 4'b0110, 1'b0, 1'b1, 3'd2});
    set_vec(4, "zero_strobe",   {32'h1234_5678, 4'b0000, 1'b0, 1'b0, 3'd0});
    set_vec(5, "send_all_0010", {32'hCAFE_F00D, 4'b0010, 1'b1, 1'b0, 3'd4});
    set_vec(6, "send_all_zero", {32'h0BAD_F00D, 4'b0000, 1'b1, 1'b1, 3'd4});
    set_vec(7, "stall_1011",    {32'h5A5A_A5A5, 4'b1011, 1'b0, 1'b1, 3'd3});
    set_vec(8, "stall_0001",    {32'h0000_00FF, 4'b0001, 1'b0, 1'b1, 3'd1});
    set_vec(9, "zero_again",    {32'hFFFF_FFFF, 4'b0000, 1'b0, 1'b1, 3'd0});
endtask

// Register port, called and left at 1 ns after the edge
task automatic cfg_write(input logic [NX_CFG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    cfg_wr_i = 1'b1;
    cfg_addr_i = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #1;
    cfg_wr_i = 1'b0;
endtask

task automatic cfg_read(input logic [NX_CFG_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    cfg_addr_i = addr;
    @(negedge clk_i);
    data = cfg_rdata_o;
    @(posedge clk_i);
    #1;
endtask

// Valid held with stable data until the FIFO takes the word
task automatic send_word(input nx_tx_word_t word);
    int   waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    tx_word_i = word;
    tx_valid_i = 1'b1;
    while (!taken) begin
        @(negedge clk_i);
        taken = tx_ready_o;
        @(posedge clk_i);
        #1;
        waited++;
        if (!taken && waited > WAIT_LIMIT) abort_on_timeout("tx_ready_o on a word push");
    end
    tx_valid_i = 1'b0;
endtask

// Optional random stalls on the consumer side
task automatic recv_word(input logic stall, output nx_rx_word_t word);
    int   waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    word = '0;
    while (!taken) begin
        rx_ready_i = stall ? (($random(seed) & 1) != 0) : 1'b1;
        @(negedge clk_i);
        taken = rx_valid_o && rx_ready_i;
        if (taken) word = rx_word_o;
        @(posedge clk_i);
        #1;
        waited++;
        if (!taken && waited > WAIT_LIMIT) abort_on_timeout("an output word on rx_valid_o");
    end
    rx_ready_i = 1'b0;
endtask

task automatic wait_drops(input int target);
    logic [31:0] drops;
    int          waited;
    waited = 0;
    cfg_read(NX_CFG_DROPS, drops);
    while (drops < 32'(target)) begin
        waited++;
        if (waited > WAIT_LIMIT) abort_on_timeout("the drop counter to advance");
        cfg_read(NX_CFG_DROPS, drops);
    end
endtask

// Fixed window in which no output word may appear
task automatic expect_quiet(input string name, input int cycles);
    for (int i = 0; i < cycles; i++) begin
        @(negedge clk_i);
        if (rx_valid_o) begin
            $display("Unexpected output word in %s while none was due", name);
            error_count++;
        end
        @(posedge clk_i);
        #1;
    end
endtask

initial begin : main
    test_vec_t               vec;
    nx_tx_word_t             word;
    nx_rx_word_t             got;
    nx_rx_word_t             exp_word;
    nx_rx_word_t             exp_q [$];
    nx_tx_word_t             burst [BURST_LEN];
    logic [NX_MAX_TICKS-1:0] mask;
    logic [31:0]             rdata;
    int                      errs;
    reset_i = 1'b1;
    tx_word_i = '0;
    tx_valid_i = 1'b0;
    rx_ready_i = 1'b0;
    cfg_wr_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    load_table();
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Table rows, one word each
    for (int t = 0; t < NUM_VECS; t++) begin
        vec = vec_table[t];
        errs = error_count;
        cfg_write(NX_CFG_CTRL, {30'b0, vec.send_all, 1'b1});
        mask = vec.send_all ? '1 : vec.strb;
        word = {vec.data, vec.strb};
        send_word(word);
        if (chunk_count(mask) == 0) begin
            model_drops++;
            wait_drops(model_drops);
            expect_quiet(vec_name[t], 8);
            cfg_read(NX_CFG_DROPS, rdata);
            check_value(vec_name[t], "drop counter", 32'(model_drops), rdata);
        end else begin
            recv_word(vec.stall, got);
            check_value(vec_name[t], "data", compact_data(vec.data, mask), got.data);
            check_value(vec_name[t], "count", 32'(vec.exp_count), 32'(got.count));
            model_words++;
            model_chunks += chunk_count(mask);
        end
        finish_test(vec_name[t], errs);
    end

    // Random burst against a stalling consumer, FIFO fills and pushes wait
    errs = error_count;
    cfg_write(NX_CFG_CTRL, 32'h1);
    for (int i = 0; i < BURST_LEN; i++) begin
        burst[i] = {32'($random(seed)), 4'($random(seed))};
        mask = burst[i].strb;
        if (chunk_count(mask) == 0) begin
            model_drops++;
        end else begin
            exp_word.data = compact_data(burst[i].data, mask);
            exp_word.count = 3'(chunk_count(mask));
            exp_q.push_back(exp_word);
            model_words++;
            model_chunks += chunk_count(mask);
        end
    end
    fork
        for (int i = 0; i < BURST_LEN; i++) send_word(burst[i]);
        foreach (exp_q[i]) begin
            recv_word(1'b1, got);
            check_value("backpressure", "data", exp_q[i].data, got.data);
            check_value("backpressure", "count", 32'(exp_q[i].count), 32'(got.count));
        end
    join
    wait_drops(model_drops);
    finish_test("backpressure", errs);

    // Disabled transmitter holds two queued words
    errs = error_count;
    cfg_write(NX_CFG_CTRL, 32'h0);
    send_word({32'h0102_0304, 4'b1111});
    send_word({32'hF0E0_D0C0, 4'b0011});
    @(negedge clk_i);
    check_value("enable_ctrl", "tx_ready_o", 32'h0, 32'(tx_ready_o));
    @(posedge clk_i);
    #1;
    expect_quiet("enable_ctrl", 16);
    cfg_write(NX_CFG_CTRL, 32'h1);
    recv_word(1'b0, got);
    check_value("enable_ctrl", "first data", compact_data(32'h0102_0304, 4'b1111), got.data);
    recv_word(1'b0, got);
    check_value("enable_ctrl", "second data", compact_data(32'hF0E0_D0C0, 4'b0011), got.data);
    model_words += 2;
    model_chunks += chunk_count(4'b1111) + chunk_count(4'b0011);
    finish_test("enable_ctrl", errs);

    // Counter read-back against model totals
    errs = error_count;
    cfg_read(NX_CFG_WORDS, rdata);
    check_value("counters", "words sent", 32'(model_words), rdata);
    cfg_read(NX_CFG_CHUNKS, rdata);
    check_value("counters", "chunks sent", 32'(model_chunks), rdata);
    cfg_read(NX_CFG_DROPS, rdata);
    check_value("counters", "words dropped", 32'(model_drops), rdata);
    finish_test("counters", errs);

    // Any write to a counter address clears it
    errs = error_count;
    cfg_write(NX_CFG_WORDS, 32'h0);
    cfg_write(NX_CFG_CHUNKS, 32'h0);
    cfg_write(NX_CFG_DROPS, 32'h0);
    cfg_read(NX_CFG_WORDS, rdata);
    check_value("counter_clear", "words sent", 32'h0, rdata);
    cfg_read(NX_CFG_CHUNKS, rdata);
    check_value("counter_clear", "chunks sent", 32'h0, rdata);
    cfg_read(NX_CFG_DROPS, rdata);
    check_value("counter_clear", "words dropped", 32'h0, rdata);
    finish_test("counter_clear", errs);

    $display("Tests run %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
             fail_count);
    if (error_count == 0) begin
        $display("All tests passed!");
    end else begin
        $display("Test failures found");
    end
    $finish;
end

endmodule

// File: tb.f
nx_pkg.sv
nx_fifo.sv
nx_transmitter.sv
nx_receiver.sv
nx_link_cfg.sv
nx_link_top.sv
tb_nx_link.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the link testbench with Verilator, pass decided from the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_nx_link -f tb.f -o sim_nx_link
./obj_dir/sim_nx_link > sim.log
cat sim.log
if grep -q 'All tests passed!' sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
